// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/add_flags.sv ====
`timescale 1ns/1ns

module add_flags (
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  input  logic [31:0]          s,
  input  logic                 c32,
  input  logic                 c16,
  input  logic                 c8,
  input  logic                 c4,
  input  alu_pkg::op_size_t    size,
  output alu_pkg::alu_flags_t  flags
);

  import alu_pkg::*;

  alu_flags_t flag8;
  alu_flags_t flag16;
  alu_flags_t flag32;
  logic       par_lo;

  assign par_lo = ~^s[7:0];  // even parity, low byte only.

  ////////////////////////////////////////
  // one flag set per operand size.
  ////////////////////////////////////////
  always_comb begin
    flag8.cf  = c8;
    flag8.pf  = par_lo;
    flag8.af  = c4;
    flag8.zf  = (s[7:0] == 8'd0);
    flag8.sf  = s[7];
    flag8.of  = (a[7] == b[7]) && (s[7] != a[7]);

    flag16.cf = c16;
    flag16.pf = par_lo;
    flag16.af = c4;
    flag16.zf = (s[15:0] == 16'd0);
    flag16.sf = s[15];
    flag16.of = (a[15] == b[15]) && (s[15] != a[15]);

    flag32.cf = c32;
    flag32.pf = par_lo;
    flag32.af = c4;
    flag32.zf = (s == 32'd0);
    flag32.sf = s[31];
    flag32.of = (a[31] == b[31]) && (s[31] != a[31]);
  end

  always_comb begin
    case (size)
      SIZE_8:  flags = flag8;
      SIZE_16: flags = flag16;
      SIZE_32: flags = flag32;
      default: flags = '0;  // reserved code.
    endcase
  end

endmodule

// ==== hw/alu_add_unit.sv ====
`timescale 1ns/1ns

module alu_add_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  alu_pkg::alu_req_t req,
  output alu_pkg::alu_rsp_t rsp,
  output logic              rsp_valid
);

  import alu_pkg::*;

  logic [31:0] sum;
  logic        c32;
  logic        c16;
  logic        c8;
  logic        c4;
  alu_flags_t  flags;

  cond_sum32 u_adder (
    .a(req.a), .b(req.b), .cin(req.cin),
    .s(sum), .cout(c32), .c16(c16), .c8(c8), .c4(c4)
  );

  add_flags u_flags (
    .a(req.a), .b(req.b), .s(sum),
    .c32(c32), .c16(c16), .c8(c8), .c4(c4),
    .size(req.size), .flags(flags)
  );

  ////////////////////////////////////////
  // response register.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (start) begin
      rsp.sum   <= sum;
      rsp.flags <= flags;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= start;  // one cycle pulse.
    end
  end

endmodule

// ==== hw/alu_apb_regs.sv ====
`timescale 1ns/1ns

module alu_apb_regs #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output alu_pkg::alu_req_t req,
  output logic              start,
  input  alu_pkg::alu_rsp_t rsp,
  input  logic              rsp_valid
);

  import alu_pkg::*;

  logic [31:0] reg_a;
  logic [31:0] reg_b;
  op_size_t    ctrl_size;
  logic        ctrl_cin;
  logic        done;
  logic [31:0] reg_result;
  alu_flags_t  reg_flags;

  logic hit_a, hit_b, hit_ctrl, hit_status, hit_result, hit_flags;
  logic decoded;
  logic access;
  logic wr_ok;
  logic [31:0] ctrl_rd;

  ////////////////////////////////////////
  // address decode.
  ////////////////////////////////////////
  assign hit_a      = (paddr == ADDR_W'(REG_A));
  assign hit_b      = (paddr == ADDR_W'(REG_B));
  assign hit_ctrl   = (paddr == ADDR_W'(REG_CTRL));
  assign hit_status = (paddr == ADDR_W'(REG_STATUS));
  assign hit_result = (paddr == ADDR_W'(REG_RESULT));
  assign hit_flags  = (paddr == ADDR_W'(REG_FLAGS));
  assign decoded    = hit_a | hit_b | hit_ctrl | hit_status | hit_result | hit_flags;

  assign access  = psel & penable;
  assign wr_ok   = access & pwrite & (hit_a | hit_b | hit_ctrl);
  assign pready  = 1'b1;  // no wait states.
  assign pslverr = access & (~decoded | (pwrite & (hit_status | hit_result | hit_flags)));

  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[CTRL_SIZE_LSB +: 2] = ctrl_size;
    ctrl_rd[CTRL_CIN_BIT]       = ctrl_cin;
  end

  always_comb begin
    prdata = '0;
    if (psel) begin
      if (hit_a)      prdata = reg_a;
      if (hit_b)      prdata = reg_b;
      if (hit_ctrl)   prdata = ctrl_rd;  // go reads as 0.
      if (hit_status) prdata[STATUS_DONE_BIT] = done;
      if (hit_result) prdata = reg_result;
      if (hit_flags)  prdata = {26'd0, reg_flags};
    end
  end

  ////////////////////////////////////////
  // register updates.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_a      <= '0;
      reg_b      <= '0;
      ctrl_size  <= SIZE_8;
      ctrl_cin   <= 1'b0;
      start      <= 1'b0;
      done       <= 1'b0;
      reg_result <= '0;
      reg_flags  <= '0;
    end else begin
      start <= wr_ok & hit_ctrl & pwdata[CTRL_GO_BIT];
      if (wr_ok && hit_a) reg_a <= pwdata;
      if (wr_ok && hit_b) reg_b <= pwdata;
      if (rsp_valid) begin
        reg_result <= rsp.sum;
        reg_flags  <= rsp.flags;
        done       <= 1'b1;
      end
      if (wr_ok && hit_ctrl) begin
        ctrl_size <= op_size_t'(pwdata[CTRL_SIZE_LSB +: 2]);
        ctrl_cin  <= pwdata[CTRL_CIN_BIT];
        done      <= 1'b0;  // newest event wins.
      end
    end
  end

  assign req = '{a: reg_a, b: reg_b, cin: ctrl_cin, size: ctrl_size};

endmodule

// ==== hw/alu_pkg.sv ====
package alu_pkg;

  typedef enum logic [1:0] {
    SIZE_8   = 2'd0,
    SIZE_16  = 2'd1,
    SIZE_32  = 2'd2,
    SIZE_RSV = 2'd3
  } op_size_t;

  // cf is the lsb.
  typedef struct packed {
    logic of;
    logic sf;
    logic zf;
    logic af;
    logic pf;
    logic cf;
  } alu_flags_t;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        cin;
    op_size_t    size;
  } alu_req_t;

  typedef struct packed {
    logic [31:0] sum;
    alu_flags_t  flags;
  } alu_rsp_t;

  ////////////////////////////////////////
  // register map.
  ////////////////////////////////////////
  localparam logic [7:0] REG_A      = 8'h00;
  localparam logic [7:0] REG_B      = 8'h04;
  localparam logic [7:0] REG_CTRL   = 8'h08;
  localparam logic [7:0] REG_STATUS = 8'h0C;
  localparam logic [7:0] REG_RESULT = 8'h10;
  localparam logic [7:0] REG_FLAGS  = 8'h14;

  localparam int unsigned CTRL_SIZE_LSB   = 0;  // two bits.
  localparam int unsigned CTRL_CIN_BIT    = 2;
  localparam int unsigned CTRL_GO_BIT     = 8;  // write only.
  localparam int unsigned STATUS_DONE_BIT = 0;

endpackage

// ==== hw/alu_top.sv ====
`timescale 1ns/1ns

module alu_top #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr
);

  import alu_pkg::*;

  alu_req_t req;
  alu_rsp_t rsp;
  logic     start;
  logic     rsp_valid;

  alu_apb_regs #(.ADDR_W(ADDR_W)) u_regs (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .req(req), .start(start), .rsp(rsp), .rsp_valid(rsp_valid)
  );

  alu_add_unit u_add (
    .clk(clk), .reset(reset), .start(start),
    .req(req), .rsp(rsp), .rsp_valid(rsp_valid)
  );

endmodule

// ==== hw/cond_sum16.sv ====
`timescale 1ns/1ns

module cond_sum16 (
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        cin,
  output logic [15:0] s,
  output logic        cout,
  output logic        c8,
  output logic        c4
);

  ////////////////////////////////////////
  // level 1: 4-bit groups, both carry-ins.
  ////////////////////////////////////////
  logic [3:0][4:0] sum_c0;  // {carry, sum}.
  logic [3:0][4:0] sum_c1;

  for (genvar g = 0; g < 4; g++) begin : g_grp
    assign sum_c0[g] = {1'b0, a[4*g +: 4]} + {1'b0, b[4*g +: 4]};
    assign sum_c1[g] = {1'b0, a[4*g +: 4]} + {1'b0, b[4*g +: 4]} + 5'd1;
  end

  ////////////////////////////////////////
  // level 2: merge group pairs into bytes.
  ////////////////////////////////////////
  logic [1:0][8:0] pair_c0;
  logic [1:0][8:0] pair_c1;

  for (genvar p = 0; p < 2; p++) begin : g_pair
    // upper group picked by the carry of the lower one.
    assign pair_c0[p] = {sum_c0[2*p][4] ? sum_c1[2*p+1] : sum_c0[2*p+1],
                         sum_c0[2*p][3:0]};
    assign pair_c1[p] = {sum_c1[2*p][4] ? sum_c1[2*p+1] : sum_c0[2*p+1],
                         sum_c1[2*p][3:0]};
  end

  ////////////////////////////////////////
  // level 3: real carry selects.
  ////////////////////////////////////////
  logic [8:0] lo_byte;
  logic [8:0] hi_byte;

  assign lo_byte = cin ? pair_c1[0] : pair_c0[0];
  assign c4      = cin ? sum_c1[0][4] : sum_c0[0][4];  // out of bit 3.
  assign c8      = lo_byte[8];
  assign hi_byte = c8 ? pair_c1[1] : pair_c0[1];

  assign s    = {hi_byte[7:0], lo_byte[7:0]};
  assign cout = hi_byte[8];

endmodule

// ==== hw/cond_sum32.sv ====
`timescale 1ns/1ns

module cond_sum32 (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        cin,
  output logic [31:0] s,
  output logic        cout,
  output logic        c16,
  output logic        c8,
  output logic        c4
);

  logic [15:0] s_hi0;
  logic [15:0] s_hi1;
  logic        cout_hi0;
  logic        cout_hi1;

  cond_sum16 u_low (
    .a(a[15:0]), .b(b[15:0]), .cin(cin),
    .s(s[15:0]), .cout(c16), .c8(c8), .c4(c4)
  );

  // upper half precomputed for both carries.
  cond_sum16 u_high0 (
    .a(a[31:16]), .b(b[31:16]), .cin(1'b0),
    .s(s_hi0), .cout(cout_hi0), .c8(), .c4()
  );

  cond_sum16 u_high1 (
    .a(a[31:16]), .b(b[31:16]), .cin(1'b1),
    .s(s_hi1), .cout(cout_hi1), .c8(), .c4()
  );

  assign s[31:16] = c16 ? s_hi1 : s_hi0;
  assign cout     = c16 ? cout_hi1 : cout_hi0;

endmodule

// ==== sim/apb_tasks.svh ====
////////////////////////////////////////
// apb transfers.
////////////////////////////////////////
task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic wr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
  int waited;
  waited = 0;
  @(posedge clk);
  #5;
  paddr   = addr;  // setup cycle.
  pwrite  = wr;
  pwdata  = wdata;
  psel    = 1'b1;
  penable = 1'b0;
  @(posedge clk);
  #5;
  penable = 1'b1;
  @(negedge clk);
  while (!pready) begin
    waited++;
    if (waited > APB_TIMEOUT) abort_run("APB transfer never saw pready");
    @(negedge clk);
  end
  rdata = prdata;  // sampled mid access cycle.
  err   = pslverr;
  @(posedge clk);
  #5;
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                         output logic err);
  logic [31:0] unused_rd;
  apb_access(addr, 1'b1, data, unused_rd, err);
endtask

task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                        output logic err);
  apb_access(addr, 1'b0, 32'd0, data, err);
endtask

////////////////////////////////////////
// compare tasks.
////////////////////////////////////////
task automatic check_sum(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
endtask

task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
  if (act !== exp) abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
endtask

// ==== sim/alu_tb.sv ====
`timescale 1ns/1ns

module alu_tb;

  import alu_pkg::*;

  localparam int ADDR_W       = 8;
  localparam int APB_TIMEOUT  = 16;
  localparam int DONE_TIMEOUT = 16;
  localparam int NUM_RANDOM   = 300;

  logic              clk;
  logic              reset;
  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;

  string    name_q[$];  // results waiting for the checker.
  alu_req_t req_q[$];
  alu_rsp_t got_q[$];
  event     captured;

  alu_top #(.ADDR_W(ADDR_W)) UUT (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  `include "apb_tasks.svh"

  ////////////////////////////////////////
  // reference model.
  ////////////////////////////////////////
  function automatic longint to_signed(input logic [31:0] v, input int w);
    longint u;
    u = longint'(v) & ((longint'(1) << w) - 1);
    if (u >= (longint'(1) << (w - 1))) u -= longint'(1) << w;
    return u;
  endfunction

  function automatic alu_rsp_t ref_add(input alu_req_t r);
    alu_rsp_t exp;
    int       w;
    int       ones;
    longint   mask;
    longint   usum;
    longint   ssum;
    exp.sum   = r.a + r.b + 32'(r.cin);
    exp.flags = '0;
    case (r.size)
      SIZE_8:  w = 8;
      SIZE_16: w = 16;
      SIZE_32: w = 32;
      default: w = 0;
    endcase
    if (w == 0) return exp;  // reserved size, no flags.
    mask = (longint'(1) << w) - 1;
    usum = (longint'(r.a) & mask) + (longint'(r.b) & mask) + longint'(r.cin);
    ssum = to_signed(r.a, w) + to_signed(r.b, w) + longint'(r.cin);
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += int'(exp.sum[i]);
    end
    exp.flags.cf = usum > mask;
    exp.flags.zf = (usum & mask) == 0;
    exp.flags.sf = (usum & mask) > (mask >> 1);
    exp.flags.of = (ssum > (mask >> 1)) || (ssum < -(mask >> 1) - 1);
    exp.flags.pf = (ones % 2) == 0;
    exp.flags.af = (int'(r.a[3:0]) + int'(r.b[3:0]) + int'(r.cin)) > 15;
    return exp;
  endfunction

  function automatic alu_req_t make_req(input logic [31:0] a, input logic [31:0] b,
                                        input logic cin, input op_size_t size);
    alu_req_t r;
    r.a    = a;
    r.b    = b;
    r.cin  = cin;
    r.size = size;
    return r;
  endfunction

  function automatic logic [31:0] ctrl_word(input alu_req_t r, input logic go);
    logic [31:0] w;
    w = '0;
    w[CTRL_SIZE_LSB +: 2] = r.size;
    w[CTRL_CIN_BIT]       = r.cin;
    w[CTRL_GO_BIT]        = go;
    return w;
  endfunction

  ////////////////////////////////////////
  // operation helpers.
  ////////////////////////////////////////
  task automatic start_add(input alu_req_t r);
    logic err;
    apb_write(REG_A, r.a, err);
    check_bit("write A pslverr", 1'b0, err);
    apb_write(REG_B, r.b, err);
    check_bit("write B pslverr", 1'b0, err);
    apb_write(REG_CTRL, ctrl_word(r, 1'b1), err);
    check_bit("write CTRL pslverr", 1'b0, err);
  endtask

  task automatic wait_done(input string name);
    logic [31:0] rd;
    logic        err;
    int          polls;
    polls = 0;
    apb_read(REG_STATUS, rd, err);
    while (!rd[STATUS_DONE_BIT]) begin
      polls++;
      if (polls > DONE_TIMEOUT) abort_run({name, ": STATUS.done never came up"});
      apb_read(REG_STATUS, rd, err);
    end
  endtask

  task automatic collect_result(input string name, input alu_req_t r);
    alu_rsp_t    got;
    logic [31:0] rd;
    logic        err;
    wait_done(name);
    apb_read(REG_RESULT, rd, err);
    got.sum = rd;
    apb_read(REG_FLAGS, rd, err);
    got.flags = alu_flags_t'(rd[5:0]);
    name_q.push_back(name);
    req_q.push_back(r);
    got_q.push_back(got);
    -> captured;
  endtask

  task automatic run_add(input string name, input alu_req_t r);
    start_add(r);
    collect_result(name, r);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // checking process.
  initial begin
    alu_rsp_t exp;
    alu_rsp_t got;
    alu_req_t r;
    string    name;
    forever begin
      @(captured);
      while (name_q.size() > 0) begin
        name = name_q.pop_front();
        r    = req_q.pop_front();
        got  = got_q.pop_front();
        exp  = ref_add(r);
        check_sum({name, " sum"}, exp.sum, got.sum);
        check_flags({name, " flags"}, exp.flags, got.flags);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus.
  ////////////////////////////////////////
  initial begin
    alu_req_t    r;
    logic [31:0] rd;
    logic [31:0] saved;
    logic        err;
    int          polls;
    op_size_t    sizes [4];
    logic [7:0]  regs [6];
    void'($urandom(79));
    sizes   = '{SIZE_8, SIZE_16, SIZE_32, SIZE_RSV};
    regs    = '{REG_A, REG_B, REG_CTRL, REG_STATUS, REG_RESULT, REG_FLAGS};
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (16) @(posedge clk);
    #5;
    reset = 1'b0;

    foreach (regs[i]) begin
      apb_read(regs[i], rd, err);
      check_sum($sformatf("reset value of reg %h", regs[i]), 32'd0, rd);
      check_bit("reset read pslverr", 1'b0, err);
    end

    // result lands one clock after the go write.
    r = make_req(32'h1234_5678, 32'h1111_1111, 1'b0, SIZE_32);
    start_add(r);
    apb_read(REG_STATUS, rd, err);
    check_bit("done on first read after go", 1'b1, rd[STATUS_DONE_BIT]);
    collect_result("latency", r);
    apb_read(REG_RESULT, saved, err);
    // flipped cin would change the sum if this write started an add.
    apb_write(REG_CTRL, ctrl_word(make_req(r.a, r.b, ~r.cin, r.size), 1'b0), err);
    check_bit("CTRL write pslverr", 1'b0, err);
    apb_read(REG_STATUS, rd, err);
    check_bit("done after CTRL write without go", 1'b0, rd[STATUS_DONE_BIT]);
    apb_read(REG_RESULT, rd, err);
    check_sum("result kept without go", saved, rd);

    run_add("0+0", make_req(32'h0, 32'h0, 1'b0, SIZE_32));
    run_add("0+0+cin", make_req(32'h0, 32'h0, 1'b1, SIZE_32));
    run_add("ffffffff+1", make_req(32'hFFFF_FFFF, 32'h1, 1'b0, SIZE_32));
    run_add("7fffffff+1", make_req(32'h7FFF_FFFF, 32'h1, 1'b0, SIZE_32));
    run_add("80000000+80000000", make_req(32'h8000_0000, 32'h8000_0000, 1'b0, SIZE_32));
    run_add("0f+01", make_req(32'h0000_000F, 32'h1, 1'b0, SIZE_32));

    for (int i = 0; i < NUM_RANDOM; i++) begin
      r.a   = $urandom;
      r.b   = (i % 8 == 0) ? ~r.a : $urandom;  // some sums wrap to zero.
      r.cin = 1'($urandom & 1);
      foreach (sizes[k]) begin
        r.size = sizes[k];
        run_add($sformatf("random %0d size %s", i, r.size.name()), r);
      end
    end

    // second go overwrites the first.
    start_add(make_req(32'h0000_0100, 32'h0000_0200, 1'b0, SIZE_16));
    run_add("back to back", make_req(32'hCAFE_0000, 32'h0000_BEEF, 1'b1, SIZE_32));

    apb_read(REG_RESULT, saved, err);
    apb_read(8'h18, rd, err);
    check_bit("undecoded read pslverr", 1'b1, err);
    apb_write(REG_RESULT, 32'hDEAD_BEEF, err);
    check_bit("RESULT write pslverr", 1'b1, err);
    apb_read(REG_RESULT, rd, err);
    check_bit("RESULT read pslverr", 1'b0, err);
    check_sum("RESULT after rejected write", saved, rd);

    polls = 0;
    while (name_q.size() > 0) begin
      polls++;
      if (polls > DONE_TIMEOUT) abort_run("checker left results unchecked");
      @(posedge clk);
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+sim
hw/alu_pkg.sv
hw/cond_sum16.sv
hw/cond_sum32.sv
hw/add_flags.sv
hw/alu_add_unit.sv
hw/alu_apb_regs.sv
hw/alu_top.sv
sim/alu_tb.sv
